/* Bender.yml */
package:
  name: fomu_echo

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/serial_pkg.sv
      - source/board_pkg.sv
      - source/serial_rx.sv
      - source/serial_tx.sv
      - source/uart.sv
      - source/fomu_echo.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/tb_fomu_echo.sv

/* bench/tb_fomu_echo.sv */
// 8N1 echo testbench at the header's fixed rate; the tx decoder assumes no baud drift
`timescale 1ns/1ps
`include "uart_settings.svh"

module tb_fomu_echo
  import serial_pkg::*;
  import board_pkg::*;
();

  localparam int CLK_PERIOD = 8;                         // ns
  localparam int BIT_NS     = `BIT_CYCLES * CLK_PERIOD;
  localparam int NUM_ROWS   = 12;
  localparam int BREAK_BITS = 12;                        // low time of a break row
  localparam logic [31:0] SEED = 32'h2823_5203;

  typedef enum logic [1:0] {FRAME_NORMAL, FRAME_BAD_STOP, FRAME_BREAK} frame_kind_e;

  typedef struct packed {
    frame_kind_e kind;
    uart_byte_t  data;
    logic [3:0]  gap;   // idle bit times after the frame
    logic        echo;  // echo expected
  } stim_row_t;

  logic       clk;
  logic       rst;
  logic       rx;
  logic       tx;
  led_t       leds;
  stim_row_t  rows [NUM_ROWS];
  uart_byte_t echo_q[$];    // bytes decoded from tx
  uart_byte_t expect_q[$];  // bytes the rows should echo
  bit         table_ready;
  int         checks;
  int         value_errors;
  int         other_errors;

  fomu_echo i_fomu_echo (
    .clk  (clk),
    .rst  (rst),
    .rx   (rx),
    .tx   (tx),
    .leds (leds)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic stim_row_t make_row(frame_kind_e kind, uart_byte_t data,
                                         logic [3:0] gap, logic echo);
    stim_row_t row;
    row.kind = kind;
    row.data = data;
    row.gap  = gap;
    row.echo = echo;
    return row;
  endfunction

  function automatic uart_byte_t random_byte();
    logic [31:0] rnd;
    rnd = $urandom;
    return rnd[7:0];  // low byte only
  endfunction

  task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    checks++;
    if (act !== exp)
    begin
      value_errors++;
      $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_led(input string name, input led_t exp, input led_t act);
    checks++;
    if (act !== exp)
    begin
      value_errors++;
      $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic expect_level(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      value_errors++;
      $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // one bit time on rx with an optional LED check at mid-bit
  task automatic drive_bit(input logic level, input bit check);
    led_t exp_led;
    for (int i = 0; i < `BIT_CYCLES; i++)
    begin
      @(posedge clk);
      if (i == 0)
        rx <= level;
      if (check && i == `HALF_BIT_CYCLES)
      begin
        @(negedge clk);  // settled point
        exp_led.r = ~level;
        exp_led.g = ~tx;
        exp_led.b = 1'b0;  // no break outside break rows
        check_led("leds", exp_led, leds);
      end
    end
  endtask

  task automatic send_row(input stim_row_t row);
    led_t exp_led;
    int   n;
    if (row.echo)
      expect_q.push_back(row.data);
    if (row.kind == FRAME_BREAK)
    begin
      for (int i = 0; i < BREAK_BITS; i++)
        drive_bit(1'b0, 1'b0);  // brk rises after the tenth low sample
      @(negedge clk);
      exp_led.r = 1'b1;
      exp_led.g = ~tx;
      exp_led.b = 1'b1;
      check_led("leds in break", exp_led, leds);
      @(posedge clk);
      rx <= 1'b1;  // release the line
      n = 0;
      while (leds.b !== 1'b0 && n < 16)  // sync flops plus one
      begin
        @(negedge clk);
        n++;
      end
      if (leds.b !== 1'b0)
      begin
        other_errors++;
        $display("break LED still lit %0d cycles after rx went high, at %0t", n, $time);
      end
    end
    else
    begin
      drive_bit(1'b0, 1'b1);  // start
      for (int i = 0; i < 8; i++)
        drive_bit(row.data[i], 1'b1);  // LSB first
      drive_bit(row.kind == FRAME_NORMAL, 1'b1);  // stop bit is low on a bad-stop row
    end
    for (int i = 0; i < row.gap; i++)
      drive_bit(1'b1, 1'b1);
  endtask

  task automatic report_counts();
    $display("summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors);
  endtask

  // tx decoder samples mid-bit on the falling clock edge
  initial
  begin : decode_tx
    uart_byte_t shift;
    shift = '0;
    forever
    begin
      @(negedge clk);
      if (tx === 1'b0)
      begin
        repeat (`HALF_BIT_CYCLES - 1) @(negedge clk);  // middle of start bit
        if (tx !== 1'b0)
        begin
          other_errors++;
          $display("tx start bit shorter than half a bit at %0t", $time);
        end
        else
        begin
          for (int i = 0; i < 8; i++)
          begin
            repeat (`BIT_CYCLES) @(negedge clk);
            shift = {tx, shift[7:1]};
          end
          repeat (`BIT_CYCLES) @(negedge clk);
          if (tx !== 1'b1)
          begin
            other_errors++;
            $display("tx stop bit low at %0t, byte dropped", $time);
          end
          else
            echo_q.push_back(shift);
        end
      end
    end
  end

  // watchdog sized from the table
  initial
  begin : watchdog
    longint unsigned limit_ns;
    int              breaks;
    breaks = 0;
    wait (table_ready);
    for (int i = 0; i < NUM_ROWS; i++)
      if (rows[i].kind == FRAME_BREAK)
        breaks++;
    limit_ns = longint'(NUM_ROWS) * 24 * 10 * BIT_NS   // 24 frame times per row
             + longint'(breaks) * BREAK_BITS * BIT_NS
             + 50 * BIT_NS;
    #(limit_ns);
    $display("timeout: run still going after %0d ns, stimulus or echo stalled", limit_ns);
    report_counts();
    $display("Testbench failed");
    $finish;
  end

  initial
  begin : main
    int n;
    rst = 1'b1;
    rx  = 1'b1;  // idle mark
    void'($urandom(SEED));
    rows[0]  = make_row(FRAME_NORMAL,   8'h55,         4'd2, 1'b1);
    rows[1]  = make_row(FRAME_NORMAL,   8'hA3,         4'd0, 1'b1);  // back to back
    rows[2]  = make_row(FRAME_NORMAL,   8'h00,         4'd0, 1'b1);
    rows[3]  = make_row(FRAME_NORMAL,   8'hFF,         4'd1, 1'b1);
    rows[4]  = make_row(FRAME_NORMAL,   random_byte(), 4'd0, 1'b1);
    rows[5]  = make_row(FRAME_BAD_STOP, 8'h5A,         4'd2, 1'b0);  // dropped
    rows[6]  = make_row(FRAME_NORMAL,   8'h3C,         4'd1, 1'b1);
    rows[7]  = make_row(FRAME_BREAK,    8'h00,         4'd3, 1'b0);
    rows[8]  = make_row(FRAME_NORMAL,   random_byte(), 4'd0, 1'b1);
    rows[9]  = make_row(FRAME_NORMAL,   random_byte(), 4'd0, 1'b1);
    rows[10] = make_row(FRAME_NORMAL,   8'h81,         4'd2, 1'b1);
    rows[11] = make_row(FRAME_NORMAL,   random_byte(), 4'd1, 1'b1);
    table_ready = 1'b1;

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    expect_level("tx after reset", 1'b1, tx);
    expect_level("leds.b after reset", 1'b0, leds.b);
    for (int i = 0; i < 20; i++)
      drive_bit(1'b1, 1'b1);  // quiet line
    if (echo_q.size() != 0)
    begin
      other_errors++;
      $display("tx produced %0d bytes while rx idled", echo_q.size());
    end

    for (int i = 0; i < NUM_ROWS; i++)
      send_row(rows[i]);

    n = 0;
    while (echo_q.size() < expect_q.size() && n < 40 * `BIT_CYCLES)
    begin
      @(negedge clk);
      n++;
    end
    for (int i = 0; i < 24; i++)
      drive_bit(1'b1, 1'b1);  // room for any stray echo

    if (echo_q.size() != expect_q.size())
    begin
      other_errors++;
      $display("tx echoed %0d bytes where %0d were expected",
               echo_q.size(), expect_q.size());
    end
    for (int i = 0; i < echo_q.size() && i < expect_q.size(); i++)
      check_byte($sformatf("echo[%0d]", i), expect_q[i], echo_q[i]);

    report_counts();
    if (value_errors == 0 && other_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* list.f */
+incdir+source
source/serial_pkg.sv
source/board_pkg.sv
source/serial_rx.sv
source/serial_tx.sv
source/uart.sv
source/fomu_echo.sv
bench/tb_fomu_echo.sv

/* source/board_pkg.sv */
// board-level types for the echo top; LED levels are active high, no PWM or current control
package board_pkg;

  // one level per LED colour
  typedef struct packed {
    logic r;  // rx activity
    logic g;  // tx activity
    logic b;  // break
  } led_t;

  // echo control states
  // idle waits for a byte and a free transmitter
  typedef enum logic {
    ECHO_IDLE,       // nothing in flight
    ECHO_WAIT_BUSY   // wr raised, waiting for busy
  } echo_state_e;

endpackage

/* source/fomu_echo.sv */
// echo top, every good rx byte is sent back on tx; LEDs are plain active-high levels, no driver
`timescale 1ns/1ps

module fomu_echo
  import serial_pkg::*;
  import board_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic rx,    // from host
  output logic tx,    // to host
  output led_t leds   // r rx, g tx, b break
);

  rx_status_t  status;   // from the receiver
  tx_req_t     request;  // to the transmitter
  logic        busy;
  logic        rd;       // one-cycle ack
  logic        wr_q;
  uart_byte_t  tx_data_q;
  echo_state_e state;

  uart i_uart (
    .clk     (clk),
    .rst     (rst),
    .rx      (rx),
    .rd      (rd),
    .request (request),
    .status  (status),
    .busy    (busy),
    .tx      (tx)
  );

  // echo control
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= ECHO_IDLE;
      rd    <= 1'b0;
      wr_q  <= 1'b0;
    end
    else
    begin
      rd <= 1'b0;  // pulse only
      case (state)
        ECHO_IDLE:
          if (status.valid && !busy)  // byte waits in status while tx runs
          begin
            rd    <= 1'b1;
            wr_q  <= 1'b1;
            state <= ECHO_WAIT_BUSY;
          end
        ECHO_WAIT_BUSY:
          if (busy)
          begin
            wr_q  <= 1'b0;  // accepted
            state <= ECHO_IDLE;
          end
        default:
          state <= ECHO_IDLE;
      endcase
    end
  end

  // copy of the byte being echoed
  always_ff @(posedge clk)
  begin
    if (state == ECHO_IDLE && status.valid && !busy)
      tx_data_q <= status.data;
  end

  assign request = '{data: tx_data_q, wr: wr_q};

  // lit while the line is low
  assign leds = '{r: !rx, g: !tx, b: status.brk};

  // valid drops the cycle after rd, so a second ack would be a stale read
  a_rd_single: assert property (@(posedge clk) disable iff (rst)
    rd |=> !rd);

endmodule

/* source/serial_pkg.sv */
// serial byte and strobe types shared by the receiver, transmitter and their users; 8 data bits only
package serial_pkg;

  // one data word on the line, LSB sent first
  typedef logic [7:0] uart_byte_t;

  // receiver view toward the consumer
  // data is held while valid is high
  // brk is a level, high while the line sits low
  typedef struct packed {
    uart_byte_t data;   // last good byte
    logic       valid;  // byte waiting, cleared by rd
    logic       brk;    // line break seen
  } rx_status_t;

  // request from the producer into the transmitter
  // wr is a level, held until busy is seen high
  typedef struct packed {
    uart_byte_t data;  // byte to frame
    logic       wr;    // send request
  } tx_req_t;

  // 10 + 9 bits total across the two structs
  // no parity field and no framing error flag
  // a frame with a bad stop bit is dropped in the receiver

endpackage

/* source/serial_rx.sv */
// 8N1 receiver with one byte of holding; rx may be asynchronous, rate fixed in the settings header
`timescale 1ns/1ps
`include "uart_settings.svh"

module serial_rx
  import serial_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,      // raw line, idles high
  input  logic       rd,      // one-cycle read pulse
  output rx_status_t status
);

  localparam int TIMER_W = $clog2(`BIT_CYCLES);
  localparam logic [TIMER_W-1:0] BIT_LAST  = TIMER_W'(`BIT_CYCLES - 1);
  localparam logic [TIMER_W-1:0] HALF_LAST = TIMER_W'(`HALF_BIT_CYCLES - 1);
  localparam logic [3:0] START_BIT = 4'd0;
  localparam logic [3:0] STOP_BIT  = 4'd9;

  logic               rx_meta;  // first sync flop
  logic               rx_sync;  // second sync flop
  logic               rx_prev;  // for edge detect
  logic               active;   // frame in progress
  logic [TIMER_W-1:0] timer;    // counts down to next sample
  logic [3:0]         bit_cnt;  // 0 start, 1..8 data, 9 stop
  uart_byte_t         shift;
  uart_byte_t         data_q;
  logic               valid_q;
  logic               brk_q;
  logic               fall;
  logic               sample;

  assign fall   = rx_prev && !rx_sync;        // start edge
  assign sample = active && (timer == '0);    // mid-bit instant

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rx_meta <= 1'b1;  // line idles high
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
      active  <= 1'b0;
      timer   <= '0;
      bit_cnt <= '0;
      valid_q <= 1'b0;
      brk_q   <= 1'b0;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      if (rd)
        valid_q <= 1'b0;  // consumer took it
      if (brk_q && rx_sync)
        brk_q <= 1'b0;    // line back high ends break
      if (!active)
      begin
        if (fall)
        begin
          active  <= 1'b1;
          timer   <= HALF_LAST;  // aim for middle of start bit
          bit_cnt <= START_BIT;
        end
      end
      else if (timer != '0)
        timer <= timer - 1'b1;
      else
      begin
        timer   <= BIT_LAST;
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == START_BIT && rx_sync)
          active <= 1'b0;  // glitch, not a start bit
        else if (bit_cnt == STOP_BIT)
        begin
          active <= 1'b0;
          if (rx_sync)
            valid_q <= 1'b1;  // good frame, overwrites any unread byte
          else if (shift == '0)
          begin
            brk_q   <= 1'b1;  // ten low samples
            valid_q <= 1'b0;  // pending byte dropped by the break
          end
          // low stop with nonzero data falls through, frame discarded
        end
      end
    end
  end

  // payload path, no reset
  always_ff @(posedge clk)
  begin
    if (sample && bit_cnt > START_BIT && bit_cnt < STOP_BIT)
      shift <= {rx_sync, shift[7:1]};  // LSB first
    if (sample && bit_cnt == STOP_BIT && rx_sync)
      data_q <= shift;
  end

  assign status = '{data: data_q, valid: valid_q, brk: brk_q};

  // a break frame must never also present a byte
  a_valid_brk_excl: assert property (@(posedge clk) disable iff (rst)
    !(status.valid && status.brk));

endmodule

/* source/serial_tx.sv */
// 8N1 transmitter, one byte per accepted wr level; no FIFO, caller waits on busy
`timescale 1ns/1ps
`include "uart_settings.svh"

module serial_tx
  import serial_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  tx_req_t request,  // data plus wr level
  output logic    busy,     // high from acceptance through stop bit
  output logic    tx        // serial line, idles high
);

  localparam int TIMER_W = $clog2(`BIT_CYCLES);
  localparam logic [TIMER_W-1:0] BIT_LAST = TIMER_W'(`BIT_CYCLES - 1);
  localparam logic [3:0] LAST_BIT = 4'd9;  // stop bit index

  logic [9:0]         shift_q;  // stop, data, start; bit 0 on the line
  logic [TIMER_W-1:0] timer;    // cycles left in current bit
  logic [3:0]         bit_cnt;  // bit now on the line

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      shift_q <= '1;  // idle mark
      timer   <= '0;
      bit_cnt <= '0;
      busy    <= 1'b0;
    end
    else if (!busy)
    begin
      if (request.wr)
      begin
        shift_q <= {1'b1, request.data, 1'b0};  // frame it
        timer   <= BIT_LAST;
        bit_cnt <= '0;
        busy    <= 1'b1;
      end
    end
    else if (timer != '0)
      timer <= timer - 1'b1;
    else
    begin
      shift_q <= {1'b1, shift_q[9:1]};  // shift in marks behind the frame
      timer   <= BIT_LAST;
      if (bit_cnt == LAST_BIT)
        busy <= 1'b0;  // stop bit done, line already high
      else
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign tx = shift_q[0];

  // the register must have drained to marks by the time busy drops
  a_idle_mark: assert property (@(posedge clk) disable iff (rst)
    !busy |-> tx);

endmodule

/* source/uart.sv */
// paired receiver and transmitter behind rd/valid/brk and wr/busy; same fixed rate both ways
`timescale 1ns/1ps

module uart
  import serial_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       rx,       // serial in
  input  logic       rd,       // ack of status.valid
  input  tx_req_t    request,  // byte and wr level
  output rx_status_t status,   // byte, valid, brk
  output logic       busy,     // transmitter occupied
  output logic       tx        // serial out
);

  // receive half
  serial_rx i_serial_rx (
    .clk    (clk),
    .rst    (rst),
    .rx     (rx),
    .rd     (rd),
    .status (status)
  );

  // transmit half
  serial_tx i_serial_tx (
    .clk     (clk),
    .rst     (rst),
    .request (request),
    .busy    (busy),
    .tx      (tx)
  );

  // acking an empty holding register would hide a protocol slip upstream
  a_rd_needs_valid: assert property (@(posedge clk) disable iff (rst)
    rd |-> status.valid);

endmodule

/* source/uart_settings.svh */
// build-time 8N1 timing at one fixed rate; the truncated bit period needs CLK_FREQ >> BAUD_RATE
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// system clock after the on-board divide-by-two
`define CLK_FREQ 24_000_000

// line rate with no runtime baud select
`define BAUD_RATE 115_200

// clock cycles per serial bit after truncation
// 24 MHz / 115200 gives 208 and runs about 0.16 % fast
`define BIT_CYCLES (`CLK_FREQ / `BAUD_RATE)

// offset from the start-bit edge to its middle
`define HALF_BIT_CYCLES (`BIT_CYCLES / 2)

// both periods feed down-counters that stop at zero,
// so each module loads the period minus one
// BIT_CYCLES must stay above 2 for the half period to exist

`endif
